// File: Bender.yml
package:
  name: rvc_fetch_frontend

sources:
  - target: rtl
    files:
      - hw/rvc_pkg.sv
      - hw/parcel_aligner.sv
      - hw/riscv_compressed_decoder.sv
      - hw/instr_sequencer.sv
      - hw/rvc_fetch_frontend.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/rvc_issue_checker.sv
      - tb/tb_rvc_frontend.sv

// File: flist.f
hw/rvc_pkg.sv
hw/parcel_aligner.sv
hw/riscv_compressed_decoder.sv
hw/instr_sequencer.sv
hw/rvc_fetch_frontend.sv
tb/tb_clk_gen.sv
tb/rvc_issue_checker.sv
tb/tb_rvc_frontend.sv

// File: hw/instr_sequencer.sv
//******************************
// picks real instruction starts out of the three slots
// and registers up to two issues per fetch word
//******************************
`timescale 1ns/1ps

module instr_sequencer import rvc_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetch_valid_i,
    input  logic [ILEN-1:0]           fetch_pc_i,
    input  logic                      held_valid_i,
    input  logic [NUM_SLOTS*ILEN-1:0] dec_instr_i,
    input  logic [NUM_SLOTS-1:0]      dec_compressed_i,
    input  logic [NUM_SLOTS-1:0]      dec_illegal_i,
    output logic                      keep_upper_o,
    output logic                      lane0_valid_o,
    output logic [ILEN-1:0]           lane0_instr_o,
    output logic [ILEN-1:0]           lane0_pc_o,
    output logic                      lane0_compressed_o,
    output logic                      lane0_illegal_o,
    output logic                      lane1_valid_o,
    output logic [ILEN-1:0]           lane1_instr_o,
    output logic [ILEN-1:0]           lane1_pc_o,
    output logic                      lane1_compressed_o,
    output logic                      lane1_illegal_o
);

    logic [1:0]     sel [NUM_LANES];   // slot feeding each lane
    logic           issue [NUM_LANES];
    logic           second_start;      // slot 2 begins an instruction
    logic           lane_vld_q [NUM_LANES];
    logic [ILEN-1:0] lane_instr_q [NUM_LANES];
    logic [ILEN-1:0] lane_pc_q [NUM_LANES];
    logic           lane_comp_q [NUM_LANES];
    logic           lane_ill_q [NUM_LANES];

    assign second_start = held_valid_i | dec_compressed_i[1];
    assign sel[0]       = held_valid_i ? 2'd0 : 2'd1;
    assign sel[1]       = 2'd2;
    assign issue[0]     = fetch_valid_i;
    assign issue[1]     = fetch_valid_i & second_start & dec_compressed_i[2];
    assign keep_upper_o = fetch_valid_i & second_start & ~dec_compressed_i[2];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_vld_q[l]   <= 1'b0;
                lane_instr_q[l] <= '0;
                lane_pc_q[l]    <= '0;
                lane_comp_q[l]  <= 1'b0;
                lane_ill_q[l]   <= 1'b0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_vld_q[l] <= issue[l]; // one cycle pulse per fetch
                if (fetch_valid_i) begin
                    lane_instr_q[l] <= dec_instr_i[sel[l]*ILEN +: ILEN];
                    lane_pc_q[l]    <= fetch_pc_i + {29'b0, sel[l], 1'b0} - 32'd2;
                    lane_comp_q[l]  <= dec_compressed_i[sel[l]];
                    lane_ill_q[l]   <= dec_illegal_i[sel[l]];
                end
            end
        end
    end

    assign lane0_valid_o      = lane_vld_q[0];
    assign lane0_instr_o      = lane_instr_q[0];
    assign lane0_pc_o         = lane_pc_q[0];
    assign lane0_compressed_o = lane_comp_q[0];
    assign lane0_illegal_o    = lane_ill_q[0];
    assign lane1_valid_o      = lane_vld_q[1];
    assign lane1_instr_o      = lane_instr_q[1];
    assign lane1_pc_o         = lane_pc_q[1];
    assign lane1_compressed_o = lane_comp_q[1];
    assign lane1_illegal_o    = lane_ill_q[1];

    // the held parcel was kept because it opened a 32-bit instruction
    a_held_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fetch_valid_i && held_valid_i) |-> !dec_compressed_i[0]);

endmodule

// File: hw/parcel_aligner.sv
//******************************
// keeps the upper parcel of a straddling instruction
// and builds one decode window per start slot
//******************************
`timescale 1ns/1ps

module parcel_aligner import rvc_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      fetch_valid_i,
    input  logic [ILEN-1:0]           fetch_data_i,
    input  logic                      flush_i,
    input  logic                      keep_upper_i,
    output logic [NUM_SLOTS*ILEN-1:0] win_o,
    output logic                      held_valid_o
);

    logic [PARCEL_W-1:0] held_parcel_q;
    logic                held_valid_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            held_valid_q <= 1'b0;
        end else if (flush_i) begin
            held_valid_q <= 1'b0; // flush beats a fetch on the same edge
        end else if (fetch_valid_i) begin
            held_valid_q <= keep_upper_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_valid_i) begin
            held_parcel_q <= fetch_data_i[ILEN-1:PARCEL_W];
        end
    end

    assign win_o[0*ILEN +: ILEN] = {fetch_data_i[PARCEL_W-1:0], held_parcel_q}; // straddler
    assign win_o[1*ILEN +: ILEN] = fetch_data_i;
    assign win_o[2*ILEN +: ILEN] = {{PARCEL_W{1'b0}}, fetch_data_i[ILEN-1:PARCEL_W]};
    assign held_valid_o          = held_valid_q;

    // a flush that lands on a word ending in a fresh straddler throws it away
    a_flush_mid_instr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(fetch_valid_i && flush_i && !held_valid_q && keep_upper_i))
        else $warning("flush drops an upper parcel that was never held");

endmodule

// File: hw/riscv_compressed_decoder.sv
//******************************
// combinational RVC to RV32 expander for one window
// NPU words and 32-bit windows pass through unchanged
//******************************
`timescale 1ns/1ps

module riscv_compressed_decoder import rvc_pkg::*; (
    input  logic [ILEN-1:0] instr_i,
    output logic [ILEN-1:0] instr_o,
    output logic            is_compressed_o,
    output logic            illegal_instr_o,
    input  logic            is_npu_insn_i
);

    logic [PARCEL_W-1:0] c;

    assign c               = instr_i[PARCEL_W-1:0];
    assign is_compressed_o = ~is_npu_insn_i & (c[1:0] != 2'b11);

    always_comb begin
        instr_o         = instr_i;
        illegal_instr_o = 1'b0;
        if (!is_npu_insn_i) begin
            case (c[1:0])
                2'b00: begin // quadrant 0
                    case (c[15:13])
                        3'b000: begin // c.addi4spn with zero uimm reserved
                            instr_o = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'h02,
                                       3'b000, 2'b01, c[4:2], OPCODE_OPIMM};
                            if (c[12:5] == 8'b0) illegal_instr_o = 1'b1;
                        end
                        3'b010: begin // c.lw
                            instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                                       3'b010, 2'b01, c[4:2], OPCODE_LOAD};
                        end
                        3'b110: begin // c.sw
                            instr_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                                       3'b010, c[11:10], c[6], 2'b00, OPCODE_STORE};
                        end
                        default: illegal_instr_o = 1'b1; // fpu loads/stores and reserved forms
                    endcase
                end

                2'b01: begin // quadrant 1
                    case (c[15:13])
                        3'b000: begin // c.addi
                            instr_o = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b0, c[11:7],
                                       OPCODE_OPIMM};
                        end
                        3'b001, 3'b101: begin // c.jal links x1 and c.j links x0
                            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                       {9{c[12]}}, 4'b0, ~c[15], OPCODE_JAL};
                        end
                        3'b010: begin // c.li
                            instr_o = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b0, c[11:7],
                                       OPCODE_OPIMM};
                            if (c[11:7] == 5'b0) illegal_instr_o = 1'b1;
                        end
                        3'b011: begin // c.lui or c.addi16sp when rd is x2
                            instr_o = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
                            if (c[11:7] == 5'h02) begin
                                instr_o = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'h02,
                                           3'b000, 5'h02, OPCODE_OPIMM};
                            end else if (c[11:7] == 5'b0) begin
                                illegal_instr_o = 1'b1;
                            end
                            if ({c[12], c[6:2]} == 6'b0) illegal_instr_o = 1'b1;
                        end
                        3'b100: begin
                            case (c[11:10])
                                2'b00, 2'b01: begin // c.srli, c.srai
                                    instr_o = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7], 3'b101,
                                               2'b01, c[9:7], OPCODE_OPIMM};
                                    if (c[12] || c[6:2] == 5'b0) illegal_instr_o = 1'b1;
                                end
                                2'b10: begin // c.andi
                                    instr_o = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], 3'b111,
                                               2'b01, c[9:7], OPCODE_OPIMM};
                                end
                                default: begin
                                    case ({c[12], c[6:5]})
                                        3'b000: begin // c.sub
                                            instr_o = {2'b01, 5'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                                       3'b000, 2'b01, c[9:7], OPCODE_OP};
                                        end
                                        3'b001: begin // c.xor
                                            instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                                       3'b100, 2'b01, c[9:7], OPCODE_OP};
                                        end
                                        3'b010: begin // c.or
                                            instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                                       3'b110, 2'b01, c[9:7], OPCODE_OP};
                                        end
                                        3'b011: begin // c.and
                                            instr_o = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                                       3'b111, 2'b01, c[9:7], OPCODE_OP};
                                        end
                                        default: illegal_instr_o = 1'b1; // rv64 subw/addw
                                    endcase
                                end
                            endcase
                        end
                        default: begin // c.beqz, c.bnez
                            instr_o = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00,
                                       c[13], c[11:10], c[4:3], c[12], OPCODE_BRANCH};
                        end
                    endcase
                end

                2'b10: begin // quadrant 2
                    case (c[15:13])
                        3'b000: begin // c.slli
                            instr_o = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPCODE_OPIMM};
                            if (c[11:7] == 5'b0 || c[12] || c[6:2] == 5'b0) begin
                                illegal_instr_o = 1'b1;
                            end
                        end
                        3'b010: begin // c.lwsp
                            instr_o = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010,
                                       c[11:7], OPCODE_LOAD};
                            if (c[11:7] == 5'b0) illegal_instr_o = 1'b1;
                        end
                        3'b100: begin
                            if (!c[12]) begin
                                if (c[6:2] == 5'b0) begin // c.jr
                                    instr_o = {12'b0, c[11:7], 3'b0, 5'b0, OPCODE_JALR};
                                    if (c[11:7] == 5'b0) illegal_instr_o = 1'b1;
                                end else begin // c.mv
                                    instr_o = {7'b0, c[6:2], 5'b0, 3'b0, c[11:7], OPCODE_OP};
                                end
                            end else if (c[11:7] == 5'b0) begin
                                // only c.ebreak is defined with rd zero
                                instr_o = {12'h001, 5'b0, 3'b0, 5'b0, OPCODE_SYSTEM};
                                if (c[6:2] != 5'b0) illegal_instr_o = 1'b1;
                            end else if (c[6:2] == 5'b0) begin // c.jalr
                                instr_o = {12'b0, c[11:7], 3'b000, 5'b00001, OPCODE_JALR};
                            end else begin // c.add
                                instr_o = {7'b0, c[6:2], c[11:7], 3'b0, c[11:7], OPCODE_OP};
                            end
                        end
                        3'b110: begin // c.swsp
                            instr_o = {4'b0, c[8:7], c[12], c[6:2], 5'h02, 3'b010, c[11:9],
                                       2'b00, OPCODE_STORE};
                        end
                        default: illegal_instr_o = 1'b1; // fpu stack forms
                    endcase
                end

                default: instr_o = instr_i; // already 32 bits
            endcase
        end
    end

endmodule

// File: hw/rvc_fetch_frontend.sv
//******************************
// RV32IC fetch front end top
// aligner, three slot decoders and two-lane issue
//******************************
`timescale 1ns/1ps

module rvc_fetch_frontend import rvc_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            fetch_valid_i,
    input  logic [ILEN-1:0] fetch_data_i,
    input  logic [ILEN-1:0] fetch_pc_i,
    input  logic            flush_i,
    input  logic            npu_mode_i,
    output logic            lane0_valid_o,
    output logic [ILEN-1:0] lane0_instr_o,
    output logic [ILEN-1:0] lane0_pc_o,
    output logic            lane0_compressed_o,
    output logic            lane0_illegal_o,
    output logic            lane1_valid_o,
    output logic [ILEN-1:0] lane1_instr_o,
    output logic [ILEN-1:0] lane1_pc_o,
    output logic            lane1_compressed_o,
    output logic            lane1_illegal_o
);

    logic [NUM_SLOTS*ILEN-1:0] win;
    logic [NUM_SLOTS*ILEN-1:0] dec_instr;
    logic [NUM_SLOTS-1:0]      dec_compressed;
    logic [NUM_SLOTS-1:0]      dec_illegal;
    logic                      held_valid;
    logic                      keep_upper;

    parcel_aligner u_aligner (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_data_i  (fetch_data_i),
        .flush_i       (flush_i),
        .keep_upper_i  (keep_upper),
        .win_o         (win),
        .held_valid_o  (held_valid)
    );

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        riscv_compressed_decoder u_dec (
            .instr_i         (win[s*ILEN +: ILEN]),
            .instr_o         (dec_instr[s*ILEN +: ILEN]),
            .is_compressed_o (dec_compressed[s]),
            .illegal_instr_o (dec_illegal[s]),
            .is_npu_insn_i   (npu_mode_i)
        );
    end

    instr_sequencer u_seq (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_pc_i         (fetch_pc_i),
        .held_valid_i       (held_valid),
        .dec_instr_i        (dec_instr),
        .dec_compressed_i   (dec_compressed),
        .dec_illegal_i      (dec_illegal),
        .keep_upper_o       (keep_upper),
        .lane0_valid_o      (lane0_valid_o),
        .lane0_instr_o      (lane0_instr_o),
        .lane0_pc_o         (lane0_pc_o),
        .lane0_compressed_o (lane0_compressed_o),
        .lane0_illegal_o    (lane0_illegal_o),
        .lane1_valid_o      (lane1_valid_o),
        .lane1_instr_o      (lane1_instr_o),
        .lane1_pc_o         (lane1_pc_o),
        .lane1_compressed_o (lane1_compressed_o),
        .lane1_illegal_o    (lane1_illegal_o)
    );

endmodule

// File: hw/rvc_pkg.sv
//******************************
// shared definitions for the RV32IC fetch front end
// import with rvc_pkg::* in the module header
//******************************
package rvc_pkg;

    localparam int ILEN      = 32; // expanded instruction width
    localparam int PARCEL_W  = 16; // one compressed parcel
    localparam int NUM_SLOTS = 3;  // held parcel, low half, high half
    localparam int NUM_LANES = 2;  // issue lanes per fetch word

    // RV32 major opcodes produced by the expander
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'h03,
        OPCODE_OPIMM  = 7'h13,
        OPCODE_STORE  = 7'h23,
        OPCODE_OP     = 7'h33,
        OPCODE_LUI    = 7'h37,
        OPCODE_BRANCH = 7'h63,
        OPCODE_JALR   = 7'h67,
        OPCODE_JAL    = 7'h6f,
        OPCODE_SYSTEM = 7'h73
    } opcode_e;

endpackage

// File: tb/rvc_issue_checker.sv
//******************************
// compares every lane issue, in lane order, with the expected queue
// the stimulus fills the queue and closes each test by name
//******************************
`timescale 1ns/1ps

module rvc_issue_checker (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        lane0_valid_i,
    input logic [31:0] lane0_instr_i,
    input logic [31:0] lane0_pc_i,
    input logic        lane0_compressed_i,
    input logic        lane0_illegal_i,
    input logic        lane1_valid_i,
    input logic [31:0] lane1_instr_i,
    input logic [31:0] lane1_pc_i,
    input logic        lane1_compressed_i,
    input logic        lane1_illegal_i
);

    logic [31:0] exp_instr [$];
    logic [31:0] exp_pc [$];
    logic        exp_comp [$];
    logic        exp_ill [$];
    logic        exp_full [$]; // 0 when only flag and pc matter

    int test_errs;
    int test_issues;
    int err_total;
    int issue_total;
    int tests_run;
    int tests_failed;

    initial begin
        test_errs    = 0;
        test_issues  = 0;
        err_total    = 0;
        issue_total  = 0;
        tests_run    = 0;
        tests_failed = 0;
    end

    task automatic push_expect(input logic [31:0] instr, input logic [31:0] pc,
                               input logic comp, input logic ill, input logic full);
        exp_instr.push_back(instr);
        exp_pc.push_back(pc);
        exp_comp.push_back(comp);
        exp_ill.push_back(ill);
        exp_full.push_back(full);
    endtask

    task automatic clear_queue();
        exp_instr.delete();
        exp_pc.delete();
        exp_comp.delete();
        exp_ill.delete();
        exp_full.delete();
    endtask

    function automatic int pending();
        return exp_pc.size();
    endfunction

    task automatic note_error();
        test_errs++;
        err_total++;
    endtask

    task automatic check_issue(input int lane, input logic [31:0] instr, input logic [31:0] pc,
                               input logic comp, input logic ill);
        logic [31:0] e_instr;
        logic [31:0] e_pc;
        logic        e_comp;
        logic        e_ill;
        logic        e_full;
        if (exp_pc.size() == 0) begin
            $display("lane%0d issued an instruction while none was expected (pc %h)", lane, pc);
            note_error();
            return;
        end
        e_instr = exp_instr.pop_front();
        e_pc    = exp_pc.pop_front();
        e_comp  = exp_comp.pop_front();
        e_ill   = exp_ill.pop_front();
        e_full  = exp_full.pop_front();
        test_issues++;
        issue_total++;
        if (pc !== e_pc) begin
            $display("Error: lane%0d_pc_o got %h expected %h", lane, pc, e_pc);
            note_error();
        end
        if (ill !== e_ill) begin
            $display("Error: lane%0d_illegal_o got %h expected %h", lane, ill, e_ill);
            note_error();
        end
        if (e_full && instr !== e_instr) begin
            $display("Error: lane%0d_instr_o got %h expected %h", lane, instr, e_instr);
            note_error();
        end
        if (e_full && comp !== e_comp) begin
            $display("Error: lane%0d_compressed_o got %h expected %h", lane, comp, e_comp);
            note_error();
        end
    endtask

    // lanes change on the rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (lane0_valid_i) begin
                check_issue(0, lane0_instr_i, lane0_pc_i, lane0_compressed_i, lane0_illegal_i);
            end
            if (lane1_valid_i) begin
                check_issue(1, lane1_instr_i, lane1_pc_i, lane1_compressed_i, lane1_illegal_i);
            end
        end
    end

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %s: ok, %0d issues", name, test_issues);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors in %0d issues", name, test_errs, test_issues);
        end
        test_errs   = 0;
        test_issues = 0;
    endtask

    task automatic report();
        $display("tests %0d, failed %0d, issues %0d, errors %0d",
                 tests_run, tests_failed, issue_total, err_total);
    endtask

endmodule

// File: tb/tb_clk_gen.sv
//******************************
// testbench clock and reset source
// 40 ns clock, reset held low for 4 cycles
//******************************
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1; // release away from the active edge
    end

endmodule

// File: tb/tb_rvc_frontend.sv
//******************************
// testbench top for the RV32IC fetch front end
// random instruction streams packed into fetch words and checked by rvc_issue_checker
//******************************
`timescale 1ns/1ps

module tb_rvc_frontend import rvc_pkg::*;;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    logic [31:0] fetch_data;
    logic [31:0] fetch_pc;
    logic        flush;
    logic        npu_mode;
    logic        l0_valid;
    logic        l0_comp;
    logic        l0_ill;
    logic        l1_valid;
    logic        l1_comp;
    logic        l1_ill;
    logic [31:0] l0_instr;
    logic [31:0] l0_pc;
    logic [31:0] l1_instr;
    logic [31:0] l1_pc;

    logic [31:0] rng;
    logic [15:0] parcels [$];      // stream as 16-bit parcels
    int          ins_start [$];
    int          ins_len [$];
    logic [31:0] ins_exp [$];
    logic        ins_comp [$];
    logic        ins_ill [$];
    logic        ins_full [$];
    logic [31:0] next_pc;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    rvc_fetch_frontend u_rvc_fetch_frontend (
        .clk_i(clk), .rst_n_i(rst_n), .fetch_valid_i(fetch_valid), .fetch_data_i(fetch_data),
        .fetch_pc_i(fetch_pc), .flush_i(flush), .npu_mode_i(npu_mode),
        .lane0_valid_o(l0_valid), .lane0_instr_o(l0_instr), .lane0_pc_o(l0_pc),
        .lane0_compressed_o(l0_comp), .lane0_illegal_o(l0_ill),
        .lane1_valid_o(l1_valid), .lane1_instr_o(l1_instr), .lane1_pc_o(l1_pc),
        .lane1_compressed_o(l1_comp), .lane1_illegal_o(l1_ill)
    );

    rvc_issue_checker u_checker (
        .clk_i(clk), .rst_n_i(rst_n),
        .lane0_valid_i(l0_valid), .lane0_instr_i(l0_instr), .lane0_pc_i(l0_pc),
        .lane0_compressed_i(l0_comp), .lane0_illegal_i(l0_ill),
        .lane1_valid_i(l1_valid), .lane1_instr_i(l1_instr), .lane1_pc_i(l1_pc),
        .lane1_compressed_i(l1_comp), .lane1_illegal_i(l1_ill)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic add_instr(input logic [31:0] bits, input int len, input logic [31:0] exp,
                             input logic comp, input logic ill, input logic full);
        ins_start.push_back(parcels.size());
        ins_len.push_back(len);
        ins_exp.push_back(exp);
        ins_comp.push_back(comp);
        ins_ill.push_back(ill);
        ins_full.push_back(full);
        parcels.push_back(bits[15:0]);
        if (len == 2) parcels.push_back(bits[31:16]);
    endtask

    task automatic add_word32();
        logic [31:0] w;
        w = next_rand() | 32'h3;
        add_instr(w, 2, w, 1'b0, 1'b0, 1'b1);
    endtask

    // legal compressed forms with expansions built from the RVC field rules
    task automatic add_compressed();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [5:0]  imm;
        logic [6:0]  uimm;
        logic [2:0]  rdp;
        logic [2:0]  rsp;
        logic [11:0] off;
        r    = next_rand();
        rd   = 5'd1 + 5'(r[15:8] % 31);
        rs2  = 5'd1 + 5'(r[23:16] % 31);
        imm  = r[29:24];
        uimm = {r[6:2], 2'b00};
        rdp  = r[10:8];
        rsp  = r[13:11];
        off  = {r[30:20], 1'b0};
        case (r[2:0] % 7)
            0: add_instr({16'h0, 3'b000, imm[5], rd, imm[4:0], 2'b01}, 1,
                         {{6{imm[5]}}, imm, rd, 3'b000, rd, OPCODE_OPIMM}, 1, 0, 1); // c.addi
            1: add_instr({16'h0, 3'b010, imm[5], rd, imm[4:0], 2'b01}, 1,
                         {{6{imm[5]}}, imm, 5'd0, 3'b000, rd, OPCODE_OPIMM}, 1, 0, 1); // c.li
            2: add_instr({16'h0, 3'b010, uimm[5:3], rsp, uimm[2], uimm[6], rdp, 2'b00}, 1,
                         {5'b0, uimm, 2'b01, rsp, 3'b010, 2'b01, rdp, OPCODE_LOAD}, 1, 0, 1);
            3: add_instr({16'h0, 3'b110, uimm[5:3], rsp, uimm[2], uimm[6], rdp, 2'b00}, 1,
                         {5'b0, uimm[6:5], 2'b01, rdp, 2'b01, rsp, 3'b010, uimm[4:0],
                          OPCODE_STORE}, 1, 0, 1); // c.sw
            4: add_instr({16'h0, 4'b1000, rd, rs2, 2'b10}, 1,
                         {7'b0, rs2, 5'd0, 3'b000, rd, OPCODE_OP}, 1, 0, 1); // c.mv
            5: add_instr({16'h0, 4'b1001, rd, rs2, 2'b10}, 1,
                         {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP}, 1, 0, 1); // c.add
            default: begin
                if (r[31]) begin // c.j
                    add_instr({16'h0, 3'b101, off[11], off[4], off[9:8], off[10], off[6],
                               off[7], off[3:1], off[5], 2'b01}, 1,
                              {off[11], off[10:1], off[11], {8{off[11]}}, 5'd0, OPCODE_JAL},
                              1, 0, 1);
                end else begin
                    add_instr(32'h9002, 1, 32'h0010_0073, 1, 0, 1); // c.ebreak
                end
            end
        endcase
    endtask

    task automatic add_illegal();
        logic [31:0] r;
        logic [15:0] p;
        r = next_rand();
        case (r[2:0] % 5)
            0: p = {3'b011, r[15:5], 2'b00}; // c.flw
            1: p = {3'b101, r[15:5], 2'b00}; // c.fsd
            2: p = 16'h0000;
            3: p = {3'b010, r[8], 5'd0, r[13:9], 2'b01}; // c.li rd zero
            default: p = {6'b100111, r[7:5], 2'b00, r[10:8], 2'b01}; // c.sub with bit 12 set
        endcase
        add_instr({16'h0, p}, 1, 32'h0, 1, 1, 0);
    endtask

    task automatic pad_even();
        if (parcels.size() % 2 != 0) add_instr(32'h0001, 1, 32'h0000_0013, 1, 0, 1); // c.nop
    endtask

    task automatic clear_stream();
        parcels.delete();
        ins_start.delete();
        ins_len.delete();
        ins_exp.delete();
        ins_comp.delete();
        ins_ill.delete();
        ins_full.delete();
    endtask

    // each instruction is expected once the word holding its last parcel goes out
    task automatic send_stream(input int nwords);
        int k;
        int i;
        i = 0;
        for (k = 0; k < nwords; k++) begin
            while (i < ins_start.size() && ins_start[i] + ins_len[i] - 1 <= 2 * k + 1) begin
                u_checker.push_expect(ins_exp[i], next_pc + 32'(2 * ins_start[i]),
                                      ins_comp[i], ins_ill[i], ins_full[i]);
                i++;
            end
            fetch_valid = 1'b1;
            fetch_data  = {parcels[2 * k + 1], parcels[2 * k]};
            fetch_pc    = next_pc + 32'(4 * k);
            @(negedge clk);
            fetch_valid = 1'b0;
            if (next_rand() % 4 == 0) @(negedge clk); // occasional idle cycle
        end
        next_pc = next_pc + 32'(4 * nwords);
        clear_stream();
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < 100 && u_checker.pending() != 0; n++) begin
            @(negedge clk);
            #1;
        end
        if (u_checker.pending() != 0) begin
            $display("timeout: expected issues never came out of the lanes");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            repeat (2) @(negedge clk); // catch stray issues
        end
    endtask

    task automatic close_test(input string name);
        wait_drain();
        u_checker.finish_test(name);
    endtask

    task automatic run_tests();
        int n;
        for (n = 0; n < 16; n++) add_word32();
        send_stream(parcels.size() / 2);
        close_test("aligned_32bit");

        pulse_flush();
        for (n = 0; n < 32; n++) add_compressed();
        send_stream(parcels.size() / 2);
        close_test("compressed_pairs");

        pulse_flush();
        for (n = 0; n < 20; n++) add_illegal();
        send_stream(parcels.size() / 2);
        close_test("illegal_forms");

        pulse_flush();
        for (n = 0; n < 60; n++) begin
            if (next_rand() % 3 == 0) add_word32();
            else add_compressed();
        end
        pad_even();
        send_stream(parcels.size() / 2);
        close_test("mixed_straddle");

        // leave a 32-bit instruction half fetched and flush it away
        pulse_flush();
        for (n = 0; n < 8; n++) add_compressed();
        if (parcels.size() % 2 == 0) add_compressed();
        add_word32();
        send_stream((parcels.size() - 1) / 2);
        wait_drain();
        u_checker.clear_queue();
        pulse_flush();
        next_pc = next_pc + 32'h100;
        for (n = 0; n < 12; n++) begin
            if (next_rand() % 2 == 0) add_word32();
            else add_compressed();
        end
        pad_even();
        send_stream(parcels.size() / 2);
        close_test("flush_held");

        pulse_flush();
        npu_mode = 1'b1;
        for (n = 0; n < 16; n++) begin
            fetch_data = next_rand();
            add_instr(fetch_data, 2, fetch_data, 1'b0, 1'b0, 1'b1);
        end
        send_stream(parcels.size() / 2);
        close_test("npu_passthrough");
        npu_mode = 1'b0;
    endtask

    initial begin
        int n;
        rng = 32'h8657_5925;
        fetch_valid = 1'b0;
        fetch_data  = '0;
        fetch_pc    = '0;
        flush       = 1'b0;
        npu_mode    = 1'b0;
        next_pc     = 32'h0000_1000;
        clear_stream();
        for (n = 0; n < 20 && !rst_n; n++) @(negedge clk);
        if (!rst_n) begin
            $display("timeout: reset never released");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            @(negedge clk);
            run_tests();
            u_checker.report();
            if (u_checker.err_total == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule
